// File: Makefile
# Verilator lint, simulation and clean for the completion back end

VERILATOR ?= verilator
TOP       ?= wb_tb
RTL_TOP   ?= wb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= -Wall --timing
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+hw
hw/wb_pkg.sv
hw/dispatch.sv
hw/inflight_queue.sv
hw/exec_unit.sv
hw/write_back.sv
hw/wb_top.sv
verif/wb_tb.sv

// File: hw/dispatch.sv
// module dispatch: issue acceptance, id allocation, idle unit selection and queue push
`timescale 1ns/1ns
`default_nettype none

`include "wb_defines.svh"

module dispatch (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       issue_valid,
    input  wire wb_pkg::issue_t       issue,
    input  wire [`WB_NUM_UNITS-1:0]   unit_busy,
    input  wire                       iq_full,
    output logic                      issue_ready,
    output logic [`WB_NUM_UNITS-1:0]  unit_start,
    output wb_pkg::unit_cmd_t         unit_cmd,
    output logic                      iq_push,
    output wb_pkg::iq_entry_t         iq_data
);

    import wb_pkg::*;

    logic [`WB_ID_WIDTH-1:0]   next_id;
    logic [`WB_UNIT_WIDTH-1:0] free_unit;
    logic                      free_found;
    logic                      accept;

    // priority encoder over idle units, scanning downward so the lowest index wins
    always_comb begin
        free_found = 1'b0;
        free_unit  = '0;
        for (int u = `WB_NUM_UNITS - 1; u >= 0; u--) begin
            if (!unit_busy[u]) begin
                free_found = 1'b1;
                free_unit  = `WB_UNIT_WIDTH'(u);
            end
        end
    end

    // the source may only strobe while this level is high
    assign issue_ready = free_found && !iq_full;
    assign accept      = issue_valid && issue_ready;

    // start pulse goes only to the chosen unit
    always_comb begin
        for (int u = 0; u < `WB_NUM_UNITS; u++) begin
            unit_start[u] = accept && (free_unit == `WB_UNIT_WIDTH'(u));
        end
    end

    // the command bus is shared, and the unit that sees start captures it
    assign unit_cmd = unit_cmd_t'{op: issue.op, operand_a: issue.operand_a,
                                  operand_b: issue.operand_b, latency: issue.latency};

    // queue record ties the current id to the unit that will hold the result
    assign iq_push = accept;
    assign iq_data = iq_entry_t'{unit_id: free_unit, id: next_id, rd_addr: issue.rd_addr};

    // ids simply wrap, and the queue never holds more entries than there are ids
    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
        end else if (accept) begin
            next_id <= next_id + 1'b1;
        end
    end

    // a strobe while no unit or queue slot is free would be dropped
    a_no_issue_when_stalled: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> issue_ready)
        else $error("issue strobe while issue_ready is low");

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
// module exec_unit: multicycle alu that times its latency and holds the result until accepted
`timescale 1ns/1ns
`default_nettype none

`include "wb_defines.svh"

module exec_unit (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire wb_pkg::unit_cmd_t    cmd,
    input  wire                       accepted,
    output logic                      busy,
    output logic                      done,
    output logic [`WB_XLEN-1:0]       result
);

    import wb_pkg::*;

    logic [`WB_LAT_WIDTH-1:0] count;

    // count is loaded with latency minus one, so latency 0 wraps to the full 8 cycles
    // done rises on the edge after count has reached zero
    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= cmd.latency - 1'b1;
        end else if (accepted) begin
            // the result has been written back, so the unit is free again
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy && !done) begin
            if (count == '0) begin
                done <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // the value is known at start and simply waits out the latency
    always_ff @(posedge clk) begin
        if (start) begin
            case (cmd.op)
                op_add: result <= cmd.operand_a + cmd.operand_b;
                op_sub: result <= cmd.operand_a - cmd.operand_b;
                op_xor: result <= cmd.operand_a ^ cmd.operand_b;
                op_and: result <= cmd.operand_a & cmd.operand_b;
                default: result <= '0;
            endcase
        end
    end

    // dispatch only starts idle units
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("start on a busy execution unit");

    // write_back only accepts a result that is there
    a_accept_needs_done: assert property (@(posedge clk) disable iff (rst)
        accepted |-> done)
        else $error("accepted without done on an execution unit");

endmodule

`default_nettype wire

// File: hw/inflight_queue.sv
// module inflight_queue: compacting age-ordered buffer of in-flight records with per-entry pop
`timescale 1ns/1ns
`default_nettype none

`include "wb_defines.svh"

module inflight_queue (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        push,
    input  wire wb_pkg::iq_entry_t     push_data,
    input  wire [`WB_IQ_DEPTH-1:0]     pop,
    output logic [`WB_IQ_DEPTH-1:0]    entry_valid,
    output wb_pkg::iq_entry_t          entries [`WB_IQ_DEPTH],
    output logic [`WB_IQ_DEPTH-1:0]    shift_pop,
    output logic                       full
);

    import wb_pkg::*;

    localparam int IDX_W = $clog2(`WB_IQ_DEPTH);

    logic [`WB_IQ_DEPTH-1:0] move_down;
    logic [`WB_IQ_DEPTH-1:0] valid_next;
    iq_entry_t               entries_next [`WB_IQ_DEPTH];
    logic [IDX_W-1:0]        push_slot;
    logic                    slot_found;
    logic                    pop_seen;

    // slot j moves down when there is a pop at or below it
    // shift_pop only counts pops strictly below, which is what write_back corrects for
    always_comb begin
        pop_seen = 1'b0;
        for (int j = 0; j < `WB_IQ_DEPTH; j++) begin
            shift_pop[j] = pop_seen;
            pop_seen     = pop_seen | pop[j];
            move_down[j] = pop_seen;
        end
    end

    // compaction first, then the push lands in the lowest slot left empty
    always_comb begin
        for (int j = 0; j < `WB_IQ_DEPTH - 1; j++) begin
            if (move_down[j]) begin
                valid_next[j]   = entry_valid[j+1];
                entries_next[j] = entries[j+1];
            end else begin
                valid_next[j]   = entry_valid[j];
                entries_next[j] = entries[j];
            end
        end
        // the top slot has nothing above it to pull down
        valid_next[`WB_IQ_DEPTH-1]   = entry_valid[`WB_IQ_DEPTH-1] && !move_down[`WB_IQ_DEPTH-1];
        entries_next[`WB_IQ_DEPTH-1] = entries[`WB_IQ_DEPTH-1];

        push_slot  = '0;
        slot_found = 1'b0;
        for (int j = `WB_IQ_DEPTH - 1; j >= 0; j--) begin
            if (!valid_next[j]) begin
                push_slot  = IDX_W'(j);
                slot_found = 1'b1;
            end
        end
        if (push && slot_found) begin
            valid_next[push_slot]   = 1'b1;
            entries_next[push_slot] = push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= valid_next;
        end
    end

    // record payload follows the valid bits and needs no clearing
    always_ff @(posedge clk) begin
        entries <= entries_next;
    end

    assign full = &entry_valid;

    // dispatch must hold off once every slot is taken
    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("push into a full in-flight queue");

    // write_back pops at most one live entry per cycle
    a_pop_valid_entry: assert property (@(posedge clk) disable iff (rst)
        ((pop & ~entry_valid) == '0) && $onehot0(pop))
        else $error("pop of an invalid entry or of more than one entry");

endmodule

`default_nettype wire

// File: hw/wb_defines.svh
// sizing macros for the completion back end: units, queue depth, data, id, unit and latency widths
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// number of execution units behind the dispatcher
`define WB_NUM_UNITS 3

// entries in the age-ordered in-flight queue
`define WB_IQ_DEPTH 4

// operand and result width
`define WB_XLEN 32

// instruction id width, the id counter wraps at 2**WB_ID_WIDTH
`define WB_ID_WIDTH 3

// enough bits to name any one execution unit
`define WB_UNIT_WIDTH 2

// latency field width, a latency of 0 stands for 2**WB_LAT_WIDTH cycles
`define WB_LAT_WIDTH 3

`endif

// File: hw/wb_pkg.sv
// package wb_pkg: alu operation enum and the packed records passed between back end blocks
`default_nettype none

`include "wb_defines.svh"

package wb_pkg;

    // operations that every execution unit can perform
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_and = 2'd3
    } alu_op_t;

    // one issue request as it arrives at the top level
    typedef struct packed {
        alu_op_t                  op;
        logic [`WB_XLEN-1:0]      operand_a;
        logic [`WB_XLEN-1:0]      operand_b;
        logic [4:0]               rd_addr;
        logic [`WB_LAT_WIDTH-1:0] latency;
    } issue_t;

    // the part of an issue that an execution unit needs to compute and time its result
    typedef struct packed {
        alu_op_t                  op;
        logic [`WB_XLEN-1:0]      operand_a;
        logic [`WB_XLEN-1:0]      operand_b;
        logic [`WB_LAT_WIDTH-1:0] latency;
    } unit_cmd_t;

    // in-flight record: which unit holds the result, the id and the destination
    typedef struct packed {
        logic [`WB_UNIT_WIDTH-1:0] unit_id;
        logic [`WB_ID_WIDTH-1:0]   id;
        logic [4:0]                rd_addr;
    } iq_entry_t;

    // register write presented at retirement
    typedef struct packed {
        logic [`WB_ID_WIDTH-1:0] id;
        logic [4:0]              rd_addr;
        logic [`WB_XLEN-1:0]     rd_data;
    } rf_write_t;

endpackage

`default_nettype wire

// File: hw/wb_top.sv
// module wb_top: dispatcher, execution unit array, in-flight queue and write-back stage
`timescale 1ns/1ns
`default_nettype none

`include "wb_defines.svh"

module wb_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    inorder,
    input  wire                    issue_valid,
    input  wire wb_pkg::issue_t    issue,
    output logic                   issue_ready,
    output logic                   wb_valid,
    output wb_pkg::rf_write_t      wb
);

    import wb_pkg::*;

    // per unit signals gathered into arrays so write_back can index them
    logic [`WB_NUM_UNITS-1:0] unit_busy;
    logic [`WB_NUM_UNITS-1:0] unit_done;
    logic [`WB_NUM_UNITS-1:0] unit_start;
    logic [`WB_NUM_UNITS-1:0] unit_accepted;
    logic [`WB_XLEN-1:0]      unit_result [`WB_NUM_UNITS];
    unit_cmd_t                unit_cmd;

    // in-flight queue signals
    logic                    iq_push;
    iq_entry_t               iq_data;
    logic                    iq_full;
    logic [`WB_IQ_DEPTH-1:0] iq_pop;
    logic [`WB_IQ_DEPTH-1:0] iq_valid;
    logic [`WB_IQ_DEPTH-1:0] iq_shift_pop;
    iq_entry_t               iq_entries [`WB_IQ_DEPTH];

    dispatch i_dispatch (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .unit_busy   (unit_busy),
        .iq_full     (iq_full),
        .issue_ready (issue_ready),
        .unit_start  (unit_start),
        .unit_cmd    (unit_cmd),
        .iq_push     (iq_push),
        .iq_data     (iq_data)
    );

    // every unit sees the same command and captures it only on its own start
    for (genvar g = 0; g < `WB_NUM_UNITS; g++) begin : g_unit
        exec_unit i_exec_unit (
            .clk      (clk),
            .rst      (rst),
            .start    (unit_start[g]),
            .cmd      (unit_cmd),
            .accepted (unit_accepted[g]),
            .busy     (unit_busy[g]),
            .done     (unit_done[g]),
            .result   (unit_result[g])
        );
    end

    inflight_queue i_inflight_queue (
        .clk         (clk),
        .rst         (rst),
        .push        (iq_push),
        .push_data   (iq_data),
        .pop         (iq_pop),
        .entry_valid (iq_valid),
        .entries     (iq_entries),
        .shift_pop   (iq_shift_pop),
        .full        (iq_full)
    );

    write_back i_write_back (
        .clk         (clk),
        .rst         (rst),
        .inorder     (inorder),
        .unit_done   (unit_done),
        .unit_result (unit_result),
        .entry_valid (iq_valid),
        .entries     (iq_entries),
        .shift_pop   (iq_shift_pop),
        .accepted    (unit_accepted),
        .pop         (iq_pop),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

endmodule

`default_nettype wire

// File: hw/write_back.sv
// module write_back: oldest-ready selection, unit acceptance, queue pop and register write
`timescale 1ns/1ns
`default_nettype none

`include "wb_defines.svh"

module write_back (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        inorder,
    input  wire [`WB_NUM_UNITS-1:0]    unit_done,
    input  wire [`WB_XLEN-1:0]         unit_result [`WB_NUM_UNITS],
    input  wire [`WB_IQ_DEPTH-1:0]     entry_valid,
    input  wire wb_pkg::iq_entry_t     entries [`WB_IQ_DEPTH],
    input  wire [`WB_IQ_DEPTH-1:0]     shift_pop,
    output logic [`WB_NUM_UNITS-1:0]   accepted,
    output logic [`WB_IQ_DEPTH-1:0]    pop,
    output logic                       wb_valid,
    output wb_pkg::rf_write_t          wb
);

    import wb_pkg::*;

    localparam int IDX_W = $clog2(`WB_IQ_DEPTH);

    iq_entry_t        sel_entry;
    iq_entry_t        sel_entry_r;
    logic [IDX_W-1:0] sel_index;
    logic [IDX_W-1:0] sel_index_corr;
    logic             sel_found;
    logic             sel_ready;
    logic             pop_matches;

    // scan from the youngest slot down so the last hit is the oldest one
    // the entry popped this cycle is already retiring and is skipped
    // in order mode the oldest live entry is chosen whether or not it is done,
    // which blocks everything younger until it finishes
    always_comb begin
        sel_found = 1'b0;
        sel_index = '0;
        sel_entry = '0;
        for (int i = `WB_IQ_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && !pop[i] &&
                    (inorder || unit_done[entries[i].unit_id])) begin
                sel_found = 1'b1;
                sel_index = IDX_W'(i);
                sel_entry = entries[i];
            end
        end
    end

    // a selection only retires once its unit has the result
    assign sel_ready = sel_found && unit_done[sel_entry.unit_id];

    // the pop is issued one cycle later, after any pop of this cycle has compacted the queue
    // an older pop moves the selected record one slot toward index 0
    assign sel_index_corr = (sel_found && shift_pop[sel_index]) ? sel_index - 1'b1 : sel_index;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            accepted <= '0;
            pop      <= '0;
        end else begin
            wb_valid <= sel_ready;
            for (int u = 0; u < `WB_NUM_UNITS; u++) begin
                accepted[u] <= sel_ready && (sel_entry.unit_id == `WB_UNIT_WIDTH'(u));
            end
            for (int i = 0; i < `WB_IQ_DEPTH; i++) begin
                pop[i] <= sel_ready && (sel_index_corr == IDX_W'(i));
            end
        end
    end

    // the record travels with wb_valid and only matters when it is high
    always_ff @(posedge clk) begin
        sel_entry_r <= sel_entry;
    end

    // the unit keeps done and its result through the accepted cycle,
    // so the data can be read straight from the unit that was picked
    always_comb begin
        wb.id      = sel_entry_r.id;
        wb.rd_addr = sel_entry_r.rd_addr;
        wb.rd_data = unit_result[sel_entry_r.unit_id];
    end

    // the popped slot must hold the record of the accepted unit once the queue has compacted
    always_comb begin
        pop_matches = 1'b1;
        for (int i = 0; i < `WB_IQ_DEPTH; i++) begin
            if (pop[i] && !accepted[entries[i].unit_id]) begin
                pop_matches = 1'b0;
            end
        end
    end

    // one retirement per cycle frees one unit and pops the record of that same unit
    a_one_accept: assert property (@(posedge clk) disable iff (rst)
        $onehot0(accepted) && pop_matches)
        else $error("accepted units do not match the popped in-flight record");

endmodule

`default_nettype wire

// File: verif/wb_tb.sv
// testbench wb_tb: stimulus table, reference rules, checks, watchdog and summary for wb_top
`timescale 1ns/1ns
`default_nettype none

`include "wb_defines.svh"

module wb_tb;

    import wb_pkg::*;

    localparam int CLK_HALF_NS  = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 10;
    localparam int MAX_ISSUES   = 4;
    localparam int MAX_LAT      = 8;
    // every row gets twice four serial issues of the longest latency, plus reset and slack
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * 2 * MAX_ISSUES * MAX_LAT + 100;
    localparam logic [31:0] SEED = 32'h418e6967;

    // one issue of a table row, operands are drawn when it is sent
    typedef struct packed {
        alu_op_t                  op;
        logic [4:0]               rd_addr;
        logic [`WB_LAT_WIDTH-1:0] latency;
    } slot_t;

    // order[k] is the issue position expected on the k-th write-back beat
    typedef struct packed {
        logic                       inorder;
        logic [2:0]                 count;
        slot_t [MAX_ISSUES-1:0]     slots;
        logic [MAX_ISSUES-1:0][1:0] order;
    } row_t;

    logic      clk;
    logic      rst;
    logic      inorder;
    logic      issue_valid;
    issue_t    issue;
    logic      issue_ready;
    logic      wb_valid;
    rf_write_t wb;

    string names [NUM_ROWS];
    row_t  rows [NUM_ROWS];
    int    num_loaded;

    // expected write of each issue position in the row being run
    logic [`WB_ID_WIDTH-1:0] exp_id [MAX_ISSUES];
    logic [`WB_XLEN-1:0]     exp_data [MAX_ISSUES];

    // ids are handed out in issue order and wrap at eight
    logic [`WB_ID_WIDTH-1:0] id_model;
    string                   cur_test;
    int                      test_errors;
    int                      tests_run;
    int                      tests_failed;

    wb_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .inorder     (inorder),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF_NS clk = ~clk;
    end

    // result rule of each operation
    function automatic logic [`WB_XLEN-1:0] alu_ref(input alu_op_t op,
                                                    input logic [`WB_XLEN-1:0] a,
                                                    input logic [`WB_XLEN-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_xor:  return a ^ b;
            default: return a & b;
        endcase
    endfunction

    function automatic slot_t make_slot(input alu_op_t op, input int rd, input int lat);
        slot_t s;
        s.op      = op;
        s.rd_addr = 5'(rd);
        s.latency = `WB_LAT_WIDTH'(lat);
        return s;
    endfunction

    task automatic add_row(input string name, input logic mode, input int count,
                           input slot_t s0, s1, s2, s3, input int o0, o1, o2, o3);
        names[num_loaded]            = name;
        rows[num_loaded].inorder     = mode;
        rows[num_loaded].count       = 3'(count);
        rows[num_loaded].slots[0]    = s0;
        rows[num_loaded].slots[1]    = s1;
        rows[num_loaded].slots[2]    = s2;
        rows[num_loaded].slots[3]    = s3;
        rows[num_loaded].order[0]    = 2'(o0);
        rows[num_loaded].order[1]    = 2'(o1);
        rows[num_loaded].order[2]    = 2'(o2);
        rows[num_loaded].order[3]    = 2'(o3);
        num_loaded++;
    endtask

    // orders follow from issue cycle plus latency, one retirement per cycle, oldest done first
    task automatic load_table();
        num_loaded = 0;
        // each operation alone, latency 0 stands for eight cycles
        add_row("add_alone", 1'b1, 1, make_slot(op_add, 3, 1), '0, '0, '0, 0, 0, 0, 0);
        add_row("sub_alone", 1'b1, 1, make_slot(op_sub, 7, 2), '0, '0, '0, 0, 0, 0, 0);
        add_row("xor_alone", 1'b0, 1, make_slot(op_xor, 12, 0), '0, '0, '0, 0, 0, 0, 0);
        add_row("and_alone", 1'b0, 1, make_slot(op_and, 31, 7), '0, '0, '0, 0, 0, 0, 0);
        // a long issue followed by two short ones, in both modes
        add_row("in_order", 1'b1, 3, make_slot(op_add, 1, 6), make_slot(op_sub, 2, 1),
                make_slot(op_xor, 3, 2), '0, 0, 1, 2, 0);
        add_row("out_of_order", 1'b0, 3, make_slot(op_add, 1, 6), make_slot(op_sub, 2, 1),
                make_slot(op_xor, 3, 2), '0, 1, 2, 0, 0);
        // issues 1 and 2 finish on the same edge and the older one goes first
        add_row("ooo_same_cycle", 1'b0, 3, make_slot(op_and, 4, 5), make_slot(op_add, 5, 2),
                make_slot(op_sub, 6, 1), '0, 1, 2, 0, 0);
        // issue 0 finishes while issue 1 retires and then beats the younger issue 2
        add_row("ooo_oldest_done", 1'b0, 3, make_slot(op_xor, 8, 4), make_slot(op_and, 9, 2),
                make_slot(op_add, 10, 1), '0, 1, 0, 2, 0);
        // the fourth issue waits for unit 0 and then overtakes the two long ones
        add_row("back_pressure", 1'b0, 4, make_slot(op_add, 11, 2), make_slot(op_sub, 13, 7),
                make_slot(op_xor, 14, 7), make_slot(op_and, 15, 1), 0, 3, 1, 2);
        // by this row the id counter has passed seven more than once
        add_row("id_wrap", 1'b1, 4, make_slot(op_sub, 16, 1), make_slot(op_add, 17, 1),
                make_slot(op_and, 18, 1), make_slot(op_xor, 19, 1), 0, 1, 2, 3);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", cur_test, test_errors);
        end else begin
            $display("test %-16s ok", cur_test);
        end
    endtask

    // sample at the falling edge, drive at the rising edge
    // busy units equal issues accepted but not yet freed, a unit frees the edge after wb_valid
    task automatic run_row(input int r);
        row_t                row;
        slot_t               s;
        issue_t              req;
        int                  issued;
        int                  retired;
        int                  outstanding;
        int                  next_outstanding;
        int                  pos;
        bit                  saw_stall;
        logic [`WB_XLEN-1:0] a;
        logic [`WB_XLEN-1:0] b;
        row         = rows[r];
        cur_test    = names[r];
        test_errors = 0;
        issued      = 0;
        retired     = 0;
        outstanding = 0;
        saw_stall   = 1'b0;
        // the mode only changes while the back end is empty
        @(posedge clk);
        inorder <= row.inorder;
        while (retired < int'(row.count) || outstanding != 0) begin
            @(negedge clk);
            check_value("issue_ready", 32'(outstanding < `WB_NUM_UNITS), 32'(issue_ready));
            if (!issue_ready) begin
                saw_stall = 1'b1;
            end
            next_outstanding = outstanding + (issue_valid ? 1 : 0) - (wb_valid ? 1 : 0);
            if (wb_valid) begin
                assert (retired < int'(row.count)) else begin
                    $display("%s: a write-back beat arrived after every issue had retired",
                             cur_test);
                    test_errors++;
                end
                if (retired < int'(row.count)) begin
                    pos = int'(row.order[retired]);
                    check_value("id", 32'(exp_id[pos]), 32'(wb.id));
                    check_value("rd_addr", 32'(row.slots[pos].rd_addr), 32'(wb.rd_addr));
                    check_value("rd_data", exp_data[pos], wb.rd_data);
                end
                retired++;
            end
            @(posedge clk);
            if (issued < int'(row.count) && next_outstanding < `WB_NUM_UNITS) begin
                s             = row.slots[issued];
                a             = $urandom();
                b             = $urandom();
                req.op        = s.op;
                req.operand_a = a;
                req.operand_b = b;
                req.rd_addr   = s.rd_addr;
                req.latency   = s.latency;
                issue_valid <= 1'b1;
                issue       <= req;
                exp_id[issued]   = id_model;
                exp_data[issued] = alu_ref(s.op, a, b);
                id_model         = id_model + 1'b1;
                issued++;
            end else begin
                issue_valid <= 1'b0;
            end
            outstanding = next_outstanding;
        end
        // three units cannot take four issues at once
        if (row.count > 3'd3) begin
            assert (saw_stall) else begin
                $display("%s: issue_ready never dropped while every unit was busy", cur_test);
                test_errors++;
            end
        end
        finish_test();
    endtask

    initial begin
        rst          = 1'b1;
        inorder      = 1'b0;
        issue_valid  = 1'b0;
        issue        = '0;
        id_model     = '0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(SEED));
        load_table();

        cur_test    = "reset_state";
        test_errors = 0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_value("wb_valid", 32'd0, 32'(wb_valid));
            check_value("issue_ready", 32'd1, 32'(issue_ready));
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("wb_valid", 32'd0, 32'(wb_valid));
        check_value("issue_ready", 32'd1, 32'(issue_ready));
        finish_test();

        for (int r = 0; r < num_loaded; r++) begin
            run_row(r);
        end

        // once drained nothing more may retire
        cur_test    = "quiet_end";
        test_errors = 0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("wb_valid", 32'd0, 32'(wb_valid));
        end
        finish_test();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF_NS);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
